// ==== design/cache_params.svh ====
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// address and data word width
`define CACHE_ADDR_BITS 32
`define CACHE_OFFSET_BITS 4
`define CACHE_WORD_SEL_BITS 2
`define CACHE_LINE_WORDS 4

// physical array of 8 ways with 64 sets each
`define CACHE_WAYS 8
`define CACHE_WAY_BITS 3
`define CACHE_MAX_INDEX_BITS 6
`define CACHE_SETS 64

// widest tag is the eight way case of 32 - 4 - 3 bits
`define CACHE_TAG_BITS 25
`define CACHE_COUNT_BITS 11

`endif

// ==== design/cache_pkg.sv ====
package cache_pkg;

  // number of active ways
  typedef enum logic [1:0]
  {
    one_way   = 2'd0,
    two_way   = 2'd1,
    four_way  = 2'd2,
    eight_way = 2'd3
  } geometry_e;

  typedef enum logic
  {
    op_read  = 1'b0,
    op_write = 1'b1
  } access_op_e;

  // st_respond means a response is waiting for resp_ready
  typedef enum logic
  {
    st_idle    = 1'b0,
    st_respond = 1'b1
  } ctrl_state_e;

endpackage

// ==== design/cache_config.sv ====
module cache_config
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cfg_valid,
  input  cache_pkg::geometry_e cfg_mode,
  input  logic                 busy,
  output logic                 cfg_ready,
  output cache_pkg::geometry_e mode,
  output logic                 invalidate
);

  cache_pkg::geometry_e mode_q;
  logic                 cfg_fire;

  // no geometry change while a response is outstanding
  assign cfg_ready = !busy;
  assign cfg_fire  = cfg_valid && cfg_ready;

  // one cycle pulse so valid bits drop at the same edge the mode changes
  assign invalidate = cfg_fire;
  assign mode       = mode_q;

  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      mode_q <= cache_pkg::one_way;
    end
    else if (cfg_fire)
    begin
      mode_q <= cfg_mode;
    end
  end

endmodule

// ==== design/address_split.sv ====
`include "cache_params.svh"

module address_split
(
  input  cache_pkg::geometry_e             mode,
  input  logic [`CACHE_ADDR_BITS-1:0]      req_addr,
  output logic [`CACHE_MAX_INDEX_BITS-1:0] index,
  output logic [`CACHE_TAG_BITS-1:0]       tag,
  output logic [`CACHE_WORD_SEL_BITS-1:0]  word_sel,
  output logic [`CACHE_WAYS-1:0]           way_mask
);

  localparam int OB = `CACHE_OFFSET_BITS;
  localparam int AB = `CACHE_ADDR_BITS;

  // bits 1..0 pick a byte within the word and are ignored
  assign word_sel = req_addr[OB-1:OB-`CACHE_WORD_SEL_BITS];

  // index shrinks by one bit each time the way count doubles
  always_comb
  begin
    case (mode)
      cache_pkg::one_way:
      begin
        index    = req_addr[OB +: 6];
        tag      = {3'b000, req_addr[AB-1:OB+6]};
        way_mask = 8'h01;
      end
      cache_pkg::two_way:
      begin
        index    = {1'b0, req_addr[OB +: 5]};
        tag      = {2'b00, req_addr[AB-1:OB+5]};
        way_mask = 8'h03;
      end
      cache_pkg::four_way:
      begin
        index    = {2'b00, req_addr[OB +: 4]};
        tag      = {1'b0, req_addr[AB-1:OB+4]};
        way_mask = 8'h0f;
      end
      default:
      begin
        index    = {3'b000, req_addr[OB +: 3]};
        tag      = req_addr[AB-1:OB+3];
        way_mask = 8'hff;
      end
    endcase
  end

endmodule

// ==== design/tag_store.sv ====
`include "cache_params.svh"

module tag_store
(
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             invalidate,
  input  logic                             accept,
  input  logic [`CACHE_MAX_INDEX_BITS-1:0] index,
  input  logic [`CACHE_TAG_BITS-1:0]       tag,
  input  logic [`CACHE_WAYS-1:0]           way_mask,
  input  cache_pkg::geometry_e             mode,
  output logic                             hit,
  output logic [`CACHE_WAY_BITS-1:0]       way
);

  logic [`CACHE_TAG_BITS-1:0] tag_q [`CACHE_WAYS][`CACHE_SETS];
  logic [`CACHE_SETS-1:0]     valid_q [`CACHE_WAYS];
  logic [`CACHE_WAYS-1:0]     match;
  logic [`CACHE_WAY_BITS-1:0] victim;

  // tag modulo the active way count
  always_comb
  begin
    case (mode)
      cache_pkg::one_way:  victim = 3'd0;
      cache_pkg::two_way:  victim = {2'b00, tag[0]};
      cache_pkg::four_way: victim = {1'b0, tag[1:0]};
      default:             victim = tag[2:0];
    endcase
  end

  always_comb
  begin
    for (int w = 0; w < `CACHE_WAYS; w++)
    begin
      match[w] = way_mask[w] && valid_q[w][index] && (tag_q[w][index] == tag);
    end
  end

  assign hit = |match;

  // lowest matching way wins, victim otherwise
  always_comb
  begin
    way = victim;
    for (int w = `CACHE_WAYS - 1; w >= 0; w--)
    begin
      if (match[w])
      begin
        way = w[`CACHE_WAY_BITS-1:0];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (!reset || invalidate)
    begin
      for (int w = 0; w < `CACHE_WAYS; w++)
      begin
        valid_q[w] <= '0;
      end
    end
    else if (accept && !hit)
    begin
      valid_q[way][index] <= 1'b1;
    end
  end

  // allocate on miss
  always_ff @(posedge clk)
  begin
    if (accept && !hit)
    begin
      tag_q[way][index] <= tag;
    end
  end

endmodule

// ==== design/data_store.sv ====
`include "cache_params.svh"

module data_store
(
  input  logic                             clk,
  input  logic                             accept,
  input  cache_pkg::access_op_e            op,
  input  logic                             hit,
  input  logic [`CACHE_WAY_BITS-1:0]       way,
  input  logic [`CACHE_MAX_INDEX_BITS-1:0] index,
  input  logic [`CACHE_WORD_SEL_BITS-1:0]  word_sel,
  input  logic [`CACHE_ADDR_BITS-1:0]      req_data,
  output logic [`CACHE_ADDR_BITS-1:0]      rd_word
);

  logic [`CACHE_ADDR_BITS-1:0] line_q [`CACHE_WAYS][`CACHE_SETS][`CACHE_LINE_WORDS];

  assign rd_word = line_q[way][index][word_sel];

  // fresh line starts zeroed since there is no next level to fill from
  // word write comes after the clear so a write miss keeps its word
  always_ff @(posedge clk)
  begin
    if (accept && !hit)
    begin
      for (int i = 0; i < `CACHE_LINE_WORDS; i++)
      begin
        line_q[way][index][i] <= '0;
      end
    end
    if (accept && op == cache_pkg::op_write)
    begin
      line_q[way][index][word_sel] <= req_data;
    end
  end

endmodule

// ==== design/access_ctrl.sv ====
`include "cache_params.svh"

module access_ctrl
(
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          req_valid,
  input  cache_pkg::access_op_e         req_op,
  input  logic [`CACHE_ADDR_BITS-1:0]   req_data,
  input  logic                          resp_ready,
  input  logic                          invalidate,
  input  logic                          hit,
  input  logic [`CACHE_ADDR_BITS-1:0]   rd_word,
  output logic                          req_ready,
  output logic                          accept,
  output logic                          busy,
  output logic                          resp_valid,
  output logic [`CACHE_ADDR_BITS-1:0]   resp_data,
  output logic                          resp_hit,
  output logic                          resp_miss,
  output logic [`CACHE_COUNT_BITS-1:0]  hit_count,
  output logic [`CACHE_COUNT_BITS-1:0]  miss_count
);

  cache_pkg::ctrl_state_e        state_q;
  logic                          resp_take;
  logic [`CACHE_ADDR_BITS-1:0]   data_q;
  logic                          hit_q;
  logic                          miss_q;
  logic [`CACHE_COUNT_BITS-1:0]  hit_cnt_q;
  logic [`CACHE_COUNT_BITS-1:0]  miss_cnt_q;

  assign busy       = (state_q == cache_pkg::st_respond);
  assign resp_valid = busy;
  assign resp_take  = busy && resp_ready;

  // geometry write owns the cycle it transfers in
  assign req_ready = !invalidate && (!busy || resp_ready);
  assign accept    = req_valid && req_ready;

  assign resp_data  = data_q;
  assign resp_hit   = hit_q;
  assign resp_miss  = miss_q;
  assign hit_count  = hit_cnt_q;
  assign miss_count = miss_cnt_q;

  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      state_q    <= cache_pkg::st_idle;
      hit_q      <= 1'b0;
      miss_q     <= 1'b0;
      hit_cnt_q  <= '0;
      miss_cnt_q <= '0;
    end
    else if (accept)
    begin
      state_q <= cache_pkg::st_respond;
      hit_q   <= hit;
      miss_q  <= !hit;
      if (hit)
      begin
        hit_cnt_q <= hit_cnt_q + 1'b1;
      end
      else
      begin
        miss_cnt_q <= miss_cnt_q + 1'b1;
      end
    end
    else if (resp_take)
    begin
      state_q <= cache_pkg::st_idle;
      hit_q   <= 1'b0;
      miss_q  <= 1'b0;
    end
  end

  // read miss returns zero and a write echoes its data
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      if (req_op == cache_pkg::op_write)
      begin
        data_q <= req_data;
      end
      else
      begin
        data_q <= hit ? rd_word : '0;
      end
    end
  end

endmodule

// ==== design/cache_top.sv ====
`include "cache_params.svh"

module cache_top
(
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          req_valid,
  output logic                          req_ready,
  input  cache_pkg::access_op_e         req_op,
  input  logic [`CACHE_ADDR_BITS-1:0]   req_addr,
  input  logic [`CACHE_ADDR_BITS-1:0]   req_data,
  output logic                          resp_valid,
  input  logic                          resp_ready,
  output logic [`CACHE_ADDR_BITS-1:0]   resp_data,
  output logic                          resp_hit,
  output logic                          resp_miss,
  input  logic                          cfg_valid,
  output logic                          cfg_ready,
  input  cache_pkg::geometry_e          cfg_mode,
  output logic [`CACHE_COUNT_BITS-1:0]  hit_count,
  output logic [`CACHE_COUNT_BITS-1:0]  miss_count
);

  cache_pkg::geometry_e             mode;
  logic                             invalidate;
  logic                             busy;
  logic                             accept;
  logic                             hit;
  logic [`CACHE_WAY_BITS-1:0]       way;
  logic [`CACHE_MAX_INDEX_BITS-1:0] index;
  logic [`CACHE_TAG_BITS-1:0]       tag;
  logic [`CACHE_WORD_SEL_BITS-1:0]  word_sel;
  logic [`CACHE_WAYS-1:0]           way_mask;
  logic [`CACHE_ADDR_BITS-1:0]      rd_word;

  cache_config config_i (.clk(clk), .reset(reset), .cfg_valid(cfg_valid),
    .cfg_mode(cfg_mode), .busy(busy), .cfg_ready(cfg_ready), .mode(mode),
    .invalidate(invalidate));

  address_split split_i (.mode(mode), .req_addr(req_addr), .index(index),
    .tag(tag), .word_sel(word_sel), .way_mask(way_mask));

  tag_store tags_i (.clk(clk), .reset(reset), .invalidate(invalidate),
    .accept(accept), .index(index), .tag(tag), .way_mask(way_mask),
    .mode(mode), .hit(hit), .way(way));

  data_store data_i (.clk(clk), .accept(accept), .op(req_op), .hit(hit),
    .way(way), .index(index), .word_sel(word_sel), .req_data(req_data),
    .rd_word(rd_word));

  // handshakes and statistics
  access_ctrl ctrl_i (.clk(clk), .reset(reset), .req_valid(req_valid),
    .req_op(req_op), .req_data(req_data), .resp_ready(resp_ready),
    .invalidate(invalidate), .hit(hit), .rd_word(rd_word),
    .req_ready(req_ready), .accept(accept), .busy(busy),
    .resp_valid(resp_valid), .resp_data(resp_data), .resp_hit(resp_hit),
    .resp_miss(resp_miss), .hit_count(hit_count), .miss_count(miss_count));

endmodule

// ==== bench/cache_tb.sv ====
`include "cache_params.svh"

module cache_tb;

  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed
  {
    logic        is_config;
    logic [1:0]  mode;
    logic        op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp_data;
    logic        exp_hit;
    logic        stall;
    logic [3:0]  stall_len;
  } entry_t;

  logic clk;
  logic reset;
  logic req_valid;
  logic req_ready;
  cache_pkg::access_op_e req_op;
  logic [`CACHE_ADDR_BITS-1:0] req_addr;
  logic [`CACHE_ADDR_BITS-1:0] req_data;
  logic resp_valid;
  logic resp_ready;
  logic [`CACHE_ADDR_BITS-1:0] resp_data;
  logic resp_hit;
  logic resp_miss;
  logic cfg_valid;
  logic cfg_ready;
  cache_pkg::geometry_e cfg_mode;
  logic [`CACHE_COUNT_BITS-1:0] hit_count;
  logic [`CACHE_COUNT_BITS-1:0] miss_count;

  entry_t      tbl [64];
  int          n_entries;
  int          errors;
  logic [15:0] lfsr_state;

  // reference model state
  int          m_mode;
  bit          m_valid [8][64];
  logic [31:0] m_tag [8][64];
  logic [31:0] m_data [8][64][4];
  int          m_hits;
  int          m_misses;

  cache_top dut_i (.clk(clk), .reset(reset), .req_valid(req_valid), .req_ready(req_ready),
    .req_op(req_op), .req_addr(req_addr), .req_data(req_data), .resp_valid(resp_valid),
    .resp_ready(resp_ready), .resp_data(resp_data), .resp_hit(resp_hit),
    .resp_miss(resp_miss), .cfg_valid(cfg_valid), .cfg_ready(cfg_ready),
    .cfg_mode(cfg_mode), .hit_count(hit_count), .miss_count(miss_count));

  always #2 clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic random_bits(input int nbits, output logic [31:0] value);
    value = '0;
    for (int b = 0; b < nbits; b++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("FAIL %0d ns %s: expected %h, actual %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic add_config(input logic [1:0] mode);
    tbl[n_entries] = '0;
    tbl[n_entries].is_config = 1'b1;
    tbl[n_entries].mode = mode;
    n_entries++;
    // geometry change drops every line
    m_mode = mode;
    for (int w = 0; w < 8; w++)
    begin
      for (int s = 0; s < 64; s++)
      begin
        m_valid[w][s] = 1'b0;
      end
    end
  endtask

  task automatic add_access(input logic op, input logic [31:0] addr,
                            input logic [31:0] data, input logic [3:0] stall_len);
    int ways;
    int sets;
    int idx;
    int word;
    int found;
    logic [31:0] tg;
    ways  = 1 << m_mode;
    sets  = 64 / ways;
    idx   = (addr >> 4) % sets;
    word  = (addr >> 2) % 4;
    tg    = addr >> (10 - m_mode);
    found = -1;
    for (int w = ways - 1; w >= 0; w--)
    begin
      if (m_valid[w][idx] && m_tag[w][idx] == tg)
      begin
        found = w;
      end
    end
    tbl[n_entries] = '0;
    tbl[n_entries].op = op;
    tbl[n_entries].addr = addr;
    tbl[n_entries].data = data;
    tbl[n_entries].exp_hit = (found >= 0);
    tbl[n_entries].stall = (stall_len != 0);
    tbl[n_entries].stall_len = stall_len;
    if (found < 0)
    begin
      found = tg % ways;
      m_valid[found][idx] = 1'b1;
      m_tag[found][idx] = tg;
      for (int i = 0; i < 4; i++)
      begin
        m_data[found][idx][i] = '0;
      end
      m_misses++;
    end
    else
    begin
      m_hits++;
    end
    if (op)
    begin
      m_data[found][idx][word] = data;
    end
    tbl[n_entries].exp_data = m_data[found][idx][word];
    n_entries++;
  endtask

  task automatic build_table();
    logic [31:0] r_op;
    logic [31:0] r_addr;
    logic [31:0] r_data;
    logic [31:0] r_stall;
    logic [31:0] r_len;
    // fresh read misses then hits
    add_access(1'b0, 32'h0000_1230, 32'h0, 4'd0);
    add_access(1'b0, 32'h0000_1230, 32'h0, 4'd0);
    random_bits(32, r_data);
    add_access(1'b1, 32'h0000_2340, r_data, 4'd0);
    add_access(1'b0, 32'h0000_2340, 32'h0, 4'd3);
    add_access(1'b0, 32'h0000_2344, 32'h0, 4'd0);
    // two tags on one index in one way mode
    for (int k = 0; k < 4; k++)
    begin
      add_access(1'b0, (k % 2 == 0) ? 32'h0001_0050 : 32'h0002_0050, 32'h0, 4'd0);
    end
    add_config(2'd3);
    for (int pass = 0; pass < 2; pass++)
    begin
      for (int t = 8; t < 16; t++)
      begin
        random_bits(32, r_data);
        add_access(pass == 0, (t << 7) | (2 << 4), r_data, 4'd0);
      end
    end
    add_config(2'd1);
    add_access(1'b0, (9 << 7) | (2 << 4), 32'h0, 4'd2);
    add_config(2'd2);
    for (int k = 0; k < 12; k++)
    begin
      random_bits(1, r_op);
      random_bits(10, r_addr);
      random_bits(32, r_data);
      random_bits(1, r_stall);
      random_bits(3, r_len);
      add_access(r_op[0], r_addr, r_data, r_stall[0] ? r_len[3:0] + 4'd1 : 4'd0);
    end
  endtask

  task automatic run_config(input int i);
    @(negedge clk);
    cfg_valid = 1'b1;
    cfg_mode = cache_pkg::geometry_e'(tbl[i].mode);
    #1;
    while (!cfg_ready)
    begin
      @(negedge clk);
      #1;
    end
    // geometry owns the transfer cycle
    check_value("req_ready", req_ready, 32'd0);
    @(negedge clk);
    cfg_valid = 1'b0;
  endtask

  task automatic run_access(input int i);
    @(negedge clk);
    req_valid = 1'b1;
    req_op = cache_pkg::access_op_e'(tbl[i].op);
    req_addr = tbl[i].addr;
    req_data = tbl[i].data;
    resp_ready = !tbl[i].stall;
    #1;
    while (!req_ready)
    begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    req_valid = 1'b0;
    check_value("resp_valid", resp_valid, 32'd1);
    check_value("resp_data", resp_data, tbl[i].exp_data);
    check_value("resp_hit", resp_hit, tbl[i].exp_hit);
    check_value("resp_miss", resp_miss, !tbl[i].exp_hit);
    for (int k = 0; k < tbl[i].stall_len; k++)
    begin
      check_value("req_ready", req_ready, 32'd0);
      check_value("resp_valid", resp_valid, 32'd1);
      check_value("resp_data", resp_data, tbl[i].exp_data);
      @(negedge clk);
    end
    resp_ready = 1'b1;
    check_value("resp_data", resp_data, tbl[i].exp_data);
    @(negedge clk);
    check_value("resp_valid", resp_valid, 32'd0);
  endtask

  initial
  begin
    clk = 1'b0;
    reset = 1'b0;
    req_valid = 1'b0;
    req_op = cache_pkg::op_read;
    req_addr = '0;
    req_data = '0;
    resp_ready = 1'b1;
    cfg_valid = 1'b0;
    cfg_mode = cache_pkg::one_way;
    errors = 0;
    n_entries = 0;
    lfsr_state = 16'd53;
    m_mode = 0;
    m_hits = 0;
    m_misses = 0;
    for (int w = 0; w < 8; w++)
    begin
      for (int s = 0; s < 64; s++)
      begin
        m_valid[w][s] = 1'b0;
      end
    end
    build_table();
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b1;
    @(negedge clk);
    check_value("hit_count", hit_count, 32'd0);
    check_value("miss_count", miss_count, 32'd0);
    check_value("resp_valid", resp_valid, 32'd0);
    check_value("resp_hit", resp_hit, 32'd0);
    check_value("resp_miss", resp_miss, 32'd0);
    check_value("req_ready", req_ready, 32'd1);
    check_value("cfg_ready", cfg_ready, 32'd1);
    for (int i = 0; i < n_entries; i++)
    begin
      if (tbl[i].is_config)
      begin
        run_config(i);
      end
      else
      begin
        run_access(i);
      end
    end
    check_value("hit_count", hit_count, m_hits % 2048);
    check_value("miss_count", miss_count, m_misses % 2048);
    $display("errors %0d, hits %0d, misses %0d", errors, hit_count, miss_count);
    if (errors == 0)
    begin
      $display("PASS: all tests");
    end
    else
    begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // watchdog allows 20 cycles per table entry after reset
  initial
  begin
    #1;
    repeat (8 + n_entries * 20) @(posedge clk);
    $display("timeout: the test table did not finish in the allowed number of cycles");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+design
design/cache_pkg.sv
design/cache_config.sv
design/address_split.sv
design/tag_store.sv
design/data_store.sv
design/access_ctrl.sv
design/cache_top.sv
bench/cache_tb.sv

// ==== Bender.yml ====
package:
  name: cache_array

sources:
  - include_dirs:
      - design
    files:
      - design/cache_pkg.sv
      - design/cache_config.sv
      - design/address_split.sv
      - design/tag_store.sv
      - design/data_store.sv
      - design/access_ctrl.sv
      - design/cache_top.sv
      - target: test
        files:
          - bench/cache_tb.sv
